// ==== compile.f ====
logic/ni_pkg.sv
logic/ni_crc32.sv
logic/ni_reg_slave.sv
logic/ni_send_dma.sv
logic/ni_flit_emitter.sv
logic/ni_send_top.sv
dv/tb_clock.sv
dv/tb_ni_send.sv

// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ni_send -f compile.f \
    && ./obj_dir/Vtb_ni_send 2>&1 | tee sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== dv/tb_ni_send.sv ====
`timescale 1ns/10ps

module tb_ni_send;
    import ni_pkg::*;

    localparam int    NUM_PACKETS = 20;
    localparam int    MAX_CYCLES  = NUM_PACKETS * 200;
    localparam word_t ENABLES     = word_t'((1 << STAT_DONE_EN) | (1 << STAT_ERR_EN));

    logic                  clk;
    logic                  reset;
    eaddr_t                src_addr_i;
    logic                  s_stb_i;
    logic                  s_we_i;
    logic [REG_ADDR_W-1:0] s_addr_i;
    word_t                 s_dat_i;
    word_t                 m_dat_i  = '0;
    logic                  m_ack_i  = 1'b0;
    logic                  credit_i = 1'b0;
    word_t                 s_dat_o;
    logic                  s_ack_o;
    logic                  irq_o;
    maddr_t                m_addr_o;
    logic                  m_cyc_o;
    logic                  m_stb_o;
    flit_t                 flit_out_o;
    logic                  flit_out_wr_o;

    // three streams split off the one seed
    word_t rng_main   = 32'd57;
    word_t rng_mem    = 32'd57 ^ 32'h5BD1_E995;
    word_t rng_credit = 32'd57 ^ 32'h27D4_EB2F;

    flit_t exp_flits[$];      // reference packets, oldest first
    int    credit_due[$];     // cycle at which each credit goes back
    int    cycle       = 0;
    int    in_flight   = 0;   // flits written minus credits returned
    int    flits_seen  = 0;
    int    flits_total = 0;
    int    mem_wait    = -1;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    ni_send_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .src_addr_i    (src_addr_i),
        .s_stb_i       (s_stb_i),
        .s_we_i        (s_we_i),
        .s_addr_i      (s_addr_i),
        .s_dat_i       (s_dat_i),
        .m_dat_i       (m_dat_i),
        .m_ack_i       (m_ack_i),
        .credit_i      (credit_i),
        .s_dat_o       (s_dat_o),
        .s_ack_o       (s_ack_o),
        .irq_o         (irq_o),
        .m_addr_o      (m_addr_o),
        .m_cyc_o       (m_cyc_o),
        .m_stb_o       (m_stb_o),
        .flit_out_o    (flit_out_o),
        .flit_out_wr_o (flit_out_wr_o)
    );

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t draw();
        rng_main = xorshift32(rng_main);
        return rng_main;
    endfunction

    // memory contents follow the whole address
    function automatic word_t mem_word(input maddr_t addr);
        return xorshift32(addr ^ 32'h9E37_79B9);
    endfunction

    // reflected crc-32, one byte, lsb first
    function automatic word_t crc_byte(input word_t crc, input logic [7:0] b);
        word_t c;
        c = crc ^ word_t'(b);
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_flit(input flit_t got, input flit_t want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s: got %b, expected %b", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input word_t data);
        @(negedge clk);
        s_stb_i  = 1'b1;
        s_we_i   = 1'b1;
        s_addr_i = addr;
        s_dat_i  = data;
        do @(negedge clk); while (!s_ack_o);
        s_stb_i = 1'b0;
        s_we_i  = 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output word_t data);
        @(negedge clk);
        s_stb_i  = 1'b1;
        s_we_i   = 1'b0;
        s_addr_i = addr;
        do @(negedge clk); while (!s_ack_o);
        data    = s_dat_o;   // valid while ack is high
        s_stb_i = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d clock cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // memory slave with 0 to 3 wait states
    always @(negedge clk) begin
        if (!reset) begin
            check_bit(m_stb_o, m_cyc_o, "read strobe against bus cycle");
            if (m_ack_i) begin
                m_ack_i = 1'b0;
            end else if (m_cyc_o && m_stb_o) begin
                if (mem_wait < 0) begin
                    rng_mem  = xorshift32(rng_mem);
                    mem_wait = int'(rng_mem % 4);
                end
                if (mem_wait == 0) begin
                    m_ack_i  = 1'b1;
                    m_dat_i  = mem_word(m_addr_o);
                    mem_wait = -1;
                end else begin
                    mem_wait = mem_wait - 1;
                end
            end
        end
    end

    // router buffer, credits come back in order after a random delay
    always @(negedge clk) begin
        flit_t want;
        if (!reset) begin
            credit_i = 1'b0;
            if (credit_due.size() != 0 && cycle >= credit_due[0]) begin
                void'(credit_due.pop_front());
                credit_i  = 1'b1;
                in_flight = in_flight - 1;
            end
            if (flit_out_wr_o) begin
                in_flight = in_flight + 1;
                if (in_flight > BUF_DEPTH) begin
                    $display("router buffer overrun: %0d flits held at %0t", in_flight, $time);
                    stop_with_failure();
                end
                rng_credit = xorshift32(rng_credit);
                credit_due.push_back(cycle + 1 + int'(rng_credit % 6));
                if (exp_flits.size() == 0) begin
                    $display("unexpected flit %h written at %0t", flit_out_o, $time);
                    stop_with_failure();
                end
                want = exp_flits.pop_front();
                if (want[FLIT_TAIL_BIT])
                    check_word(flit_out_o[31:0], want[31:0], "tail crc");
                check_flit(flit_out_o, want, "flit");
                flits_seen = flits_seen + 1;
            end
        end
    end

    initial begin
        word_t      rd;
        word_t      w;
        word_t      crc;
        size_t      size;
        maddr_t     addr;
        eaddr_t     dest;
        pck_class_t cls;

        s_stb_i    = 1'b0;
        s_we_i     = 1'b0;
        s_addr_i   = '0;
        s_dat_i    = '0;
        src_addr_i = eaddr_t'(draw());

        // model crc against the usual check value of "123456789"
        crc = '1;
        for (int i = 0; i < 9; i++) begin
            crc = crc_byte(crc, 8'h31 + 8'(i));
        end
        check_word(~crc, 32'hCBF4_3926, "crc model check value");

        wait (reset === 1'b0);
        reg_write(REG_STATUS, ENABLES);
        check_bit(irq_o, 1'b0, "irq after enables");

        // zero size start
        reg_write(REG_SIZE, '0);
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_ERRORS, rd);
        check_word(rd, word_t'(1 << ERR_SIZE), "errors after zero size start");
        check_bit(irq_o, 1'b1, "irq on size error");
        reg_read(REG_STATUS, rd);
        check_word(rd, ENABLES | word_t'(1 << STAT_ERR_ISR), "status after size error");
        reg_write(REG_STATUS, ENABLES | word_t'(1 << STAT_ERR_ISR));
        reg_read(REG_ERRORS, rd);
        check_word(rd, '0, "errors after clear");
        check_bit(irq_o, 1'b0, "irq after error clear");

        for (int p = 0; p < NUM_PACKETS; p++) begin
            size = size_t'(1 + draw() % 8);
            addr = draw() & 32'hFFFF_FFFC;
            w    = draw();
            dest = w[7:0];
            cls  = w[9:8];
            reg_write(REG_SIZE, word_t'(size));
            reg_write(REG_START_ADDR, addr);
            reg_write(REG_DEST, {22'd0, cls, dest});
            reg_read(REG_SIZE, rd);
            check_word(rd, word_t'(size), "size readback");
            reg_read(REG_START_ADDR, rd);
            check_word(rd, addr, "start address readback");
            reg_read(REG_DEST, rd);
            check_word(rd, {22'd0, cls, dest}, "dest readback");

            // expected packet
            exp_flits.push_back({1'b1, 1'b0, 14'd0, cls, src_addr_i, dest});
            crc = '1;
            for (int i = 0; i < int'(size); i++) begin
                w = mem_word(maddr_t'(addr + 4 * i));
                exp_flits.push_back({2'b00, w});
                for (int b = 0; b < 4; b++) begin
                    crc = crc_byte(crc, w[8*b +: 8]);
                end
            end
            exp_flits.push_back({1'b0, 1'b1, ~crc});
            flits_total = flits_total + int'(size) + 2;

            reg_write(REG_CTRL, 32'd1);
            if (p % 5 == 2) begin
                reg_write(REG_CTRL, 32'd1);   // lands while the packet is going out
                reg_read(REG_ERRORS, rd);
                check_word(rd, word_t'(1 << ERR_ILLEGAL_START), "errors after busy start");
                check_bit(irq_o, 1'b1, "irq on illegal start");
                reg_write(REG_STATUS, ENABLES | word_t'(1 << STAT_ERR_ISR));
                reg_read(REG_ERRORS, rd);
                check_word(rd, '0, "errors after clear");
            end

            do @(negedge clk); while (!irq_o);
            reg_read(REG_STATUS, rd);
            check_bit(rd[STAT_DONE_ISR], 1'b1, "done flag");
            check_bit(rd[STAT_ERR_ISR], 1'b0, "error flag");
            check_bit(rd[STAT_BUSY], 1'b0, "busy after packet");
            reg_write(REG_STATUS, ENABLES | word_t'(1 << STAT_DONE_ISR));
            check_bit(irq_o, 1'b0, "irq after done clear");
            if (exp_flits.size() != 0) begin
                $display("packet %0d finished with %0d flits missing", p, exp_flits.size());
                stop_with_failure();
            end
        end

        do @(negedge clk); while (credit_due.size() != 0);
        if (flits_seen != flits_total || in_flight != 0) begin
            $display("saw %0d of %0d flits, %0d credits still owed",
                     flits_seen, flits_total, in_flight);
            stop_with_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD = 50;   // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // covers the first two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== logic/ni_send_top.sv ====
`timescale 1ns/10ps

module ni_send_top (
    input  logic                          clk,
    input  logic                          reset,
    input  ni_pkg::eaddr_t                src_addr_i,
    input  logic                          s_stb_i,
    input  logic                          s_we_i,
    input  logic [ni_pkg::REG_ADDR_W-1:0] s_addr_i,
    input  ni_pkg::word_t                 s_dat_i,
    input  ni_pkg::word_t                 m_dat_i,
    input  logic                          m_ack_i,
    input  logic                          credit_i,
    output ni_pkg::word_t                 s_dat_o,
    output logic                          s_ack_o,
    output logic                          irq_o,
    output ni_pkg::maddr_t                m_addr_o,
    output logic                          m_cyc_o,
    output logic                          m_stb_o,
    output ni_pkg::flit_t                 flit_out_o,
    output logic                          flit_out_wr_o
);
    import ni_pkg::*;

    logic       send_start;
    logic       send_done;
    size_t      size;
    maddr_t     start_addr;
    eaddr_t     dest;
    pck_class_t pck_class;
    logic       item_valid;
    logic       item_ready;
    item_kind_t item_kind;
    word_t      item_word;

    ni_reg_slave u_regs (
        .clk          (clk),
        .reset        (reset),
        .s_stb_i      (s_stb_i),
        .s_we_i       (s_we_i),
        .s_addr_i     (s_addr_i),
        .s_dat_i      (s_dat_i),
        .send_done_i  (send_done),
        .s_dat_o      (s_dat_o),
        .s_ack_o      (s_ack_o),
        .irq_o        (irq_o),
        .send_start_o (send_start),
        .size_o       (size),
        .start_addr_o (start_addr),
        .dest_o       (dest),
        .class_o      (pck_class)
    );

    ni_send_dma u_dma (
        .clk          (clk),
        .reset        (reset),
        .send_start_i (send_start),
        .size_i       (size),
        .start_addr_i (start_addr),
        .m_dat_i      (m_dat_i),
        .m_ack_i      (m_ack_i),
        .item_ready_i (item_ready),
        .m_addr_o     (m_addr_o),
        .m_cyc_o      (m_cyc_o),
        .m_stb_o      (m_stb_o),
        .item_valid_o (item_valid),
        .item_kind_o  (item_kind),
        .item_word_o  (item_word)
    );

    ni_flit_emitter u_emit (
        .clk           (clk),
        .reset         (reset),
        .item_valid_i  (item_valid),
        .item_kind_i   (item_kind),
        .item_word_i   (item_word),
        .dest_i        (dest),
        .class_i       (pck_class),
        .src_addr_i    (src_addr_i),
        .credit_i      (credit_i),
        .item_ready_o  (item_ready),
        .flit_out_o    (flit_out_o),
        .flit_out_wr_o (flit_out_wr_o),
        .send_done_o   (send_done)
    );

endmodule

// ==== logic/ni_flit_emitter.sv ====
`timescale 1ns/10ps

module ni_flit_emitter (
    input  logic               clk,
    input  logic               reset,
    input  logic               item_valid_i,
    input  ni_pkg::item_kind_t item_kind_i,
    input  ni_pkg::word_t      item_word_i,
    input  ni_pkg::eaddr_t     dest_i,
    input  ni_pkg::pck_class_t class_i,
    input  ni_pkg::eaddr_t     src_addr_i,
    input  logic               credit_i,
    output logic               item_ready_o,
    output ni_pkg::flit_t      flit_out_o,
    output logic               flit_out_wr_o,
    output logic               send_done_o
);
    import ni_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [CNT_W-1:0] outstanding;   // flits sitting in the router buffer
    logic             accept;
    logic             is_hdr;
    logic             is_tail;
    word_t            hdr_word;
    word_t            crc;

    assign item_ready_o = !flit_out_wr_o && (outstanding < CNT_W'(BUF_DEPTH));
    assign accept       = item_valid_i && item_ready_o;
    assign is_hdr       = (item_kind_i == ITEM_HDR);
    assign is_tail      = (item_kind_i == ITEM_TAIL);

    always_comb begin
        hdr_word = '0;
        hdr_word[HDR_DEST_LSB +: $bits(eaddr_t)]      = dest_i;
        hdr_word[HDR_SRC_LSB +: $bits(eaddr_t)]       = src_addr_i;
        hdr_word[HDR_CLASS_LSB +: $bits(pck_class_t)] = class_i;
    end

    ni_crc32 u_crc (
        .clk      (clk),
        .reset    (reset),
        .clear_i  (accept && is_hdr),
        .enable_i (accept && (item_kind_i == ITEM_BODY)),
        .data_i   (item_word_i),
        .crc_o    (crc)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            flit_out_o[FLIT_HDR_BIT]         <= is_hdr;
            flit_out_o[FLIT_TAIL_BIT]        <= is_tail;
            flit_out_o[$bits(word_t)-1:0]    <= is_hdr ? hdr_word : (is_tail ? crc : item_word_i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out_wr_o <= 1'b0;
            send_done_o   <= 1'b0;
            outstanding   <= '0;
        end else begin
            flit_out_wr_o <= accept;
            send_done_o   <= flit_out_wr_o && flit_out_o[FLIT_TAIL_BIT];
            case ({flit_out_wr_o, credit_i})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;   // none or both
            endcase
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (reset)
        outstanding <= CNT_W'(BUF_DEPTH));

    // router only frees slots it was given
    a_credit_owed: assert property (@(posedge clk) disable iff (reset)
        credit_i |-> outstanding != '0);

endmodule

// ==== logic/ni_send_dma.sv ====
`timescale 1ns/10ps

module ni_send_dma (
    input  logic               clk,
    input  logic               reset,
    input  logic               send_start_i,
    input  ni_pkg::size_t      size_i,
    input  ni_pkg::maddr_t     start_addr_i,
    input  ni_pkg::word_t      m_dat_i,
    input  logic               m_ack_i,
    input  logic               item_ready_i,
    output ni_pkg::maddr_t     m_addr_o,
    output logic               m_cyc_o,
    output logic               m_stb_o,
    output logic               item_valid_o,
    output ni_pkg::item_kind_t item_kind_o,
    output ni_pkg::word_t      item_word_o
);
    import ni_pkg::*;

    dma_state_t state;
    dma_state_t state_next;
    size_t      words_left;
    logic       load;
    logic       push_done;

    assign load      = (state == DMA_IDLE) && send_start_i;
    assign push_done = (state == DMA_PUSH) && item_ready_i;

    always_comb begin
        state_next = state;
        case (state)
            DMA_IDLE: if (send_start_i) state_next = DMA_HDR;
            DMA_HDR:  if (item_ready_i) state_next = DMA_READ;
            DMA_READ: if (m_ack_i) state_next = DMA_PUSH;
            DMA_PUSH: begin
                if (item_ready_i)
                    state_next = (words_left == size_t'(1)) ? DMA_TAIL : DMA_READ;
            end
            DMA_TAIL: if (item_ready_i) state_next = DMA_IDLE;
            default:  state_next = DMA_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= DMA_IDLE;
            words_left <= '0;
        end else begin
            state <= state_next;
            if (load)
                words_left <= size_i;
            else if (push_done)
                words_left <= words_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            m_addr_o <= start_addr_i;
        else if (push_done)
            m_addr_o <= m_addr_o + maddr_t'(4);   // next word
        if (m_cyc_o && m_ack_i)
            item_word_o <= m_dat_i;
    end

    assign m_cyc_o      = (state == DMA_READ);
    assign m_stb_o      = (state == DMA_READ);
    assign item_valid_o = (state == DMA_HDR) || (state == DMA_PUSH) || (state == DMA_TAIL);
    assign item_kind_o  = (state == DMA_HDR)  ? ITEM_HDR :
                          (state == DMA_TAIL) ? ITEM_TAIL : ITEM_BODY;

    // classic cycle held with a steady address until the slave acks
    a_stb_hold: assert property (@(posedge clk) disable iff (reset)
        m_stb_o && !m_ack_i |=> m_stb_o && $stable(m_addr_o));

endmodule

// ==== logic/ni_reg_slave.sv ====
`timescale 1ns/10ps

module ni_reg_slave (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          s_stb_i,
    input  logic                          s_we_i,
    input  logic [ni_pkg::REG_ADDR_W-1:0] s_addr_i,
    input  ni_pkg::word_t                 s_dat_i,
    input  logic                          send_done_i,
    output ni_pkg::word_t                 s_dat_o,
    output logic                          s_ack_o,
    output logic                          irq_o,
    output logic                          send_start_o,
    output ni_pkg::size_t                 size_o,
    output ni_pkg::maddr_t                start_addr_o,
    output ni_pkg::eaddr_t                dest_o,
    output ni_pkg::pck_class_t            class_o
);
    import ni_pkg::*;

    logic       busy;
    logic       done_en;
    logic       err_en;
    logic       done_isr;
    logic       err_isr;
    logic [1:0] errors;      // sticky error bits
    logic [1:0] err_set;
    logic       wr;
    logic       stat_wr;
    logic       start_req;
    logic       clr_done;
    logic       clr_err;

    // write seen in the cycle before ack, lands on the ack edge
    assign wr        = s_stb_i & s_we_i & ~s_ack_o;
    assign stat_wr   = wr && (s_addr_i == REG_STATUS);
    assign start_req = wr && (s_addr_i == REG_CTRL) && s_dat_i[0];
    assign clr_done  = stat_wr && s_dat_i[STAT_DONE_ISR];
    assign clr_err   = stat_wr && s_dat_i[STAT_ERR_ISR];

    assign send_start_o                = start_req && !busy && (size_o != '0);
    assign err_set[ERR_ILLEGAL_START]  = start_req && busy;
    assign err_set[ERR_SIZE]           = start_req && !busy && (size_o == '0);

    assign irq_o = (done_isr & done_en) | (err_isr & err_en);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= s_stb_i & ~s_ack_o;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            done_en  <= 1'b0;
            err_en   <= 1'b0;
            done_isr <= 1'b0;
            err_isr  <= 1'b0;
            errors   <= '0;
        end else begin
            if (send_start_o)
                busy <= 1'b1;
            else if (send_done_i)
                busy <= 1'b0;
            if (stat_wr) begin
                done_en <= s_dat_i[STAT_DONE_EN];
                err_en  <= s_dat_i[STAT_ERR_EN];
            end
            // set wins over a clear in the same cycle
            done_isr <= send_done_i | (done_isr & ~clr_done);
            err_isr  <= (|err_set) | (err_isr & ~clr_err);
            errors   <= err_set | (errors & ~{2{clr_err}});
        end
    end

    // send parameters, frozen while a packet is going out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            size_o       <= '0;
            start_addr_o <= '0;
            dest_o       <= '0;
            class_o      <= '0;
        end else if (wr && !busy) begin
            case (s_addr_i)
                REG_SIZE:       size_o <= s_dat_i[$bits(size_t)-1:0];
                REG_START_ADDR: start_addr_o <= s_dat_i;
                REG_DEST: begin
                    dest_o  <= s_dat_i[7:0];
                    class_o <= s_dat_i[9:8];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        s_dat_o = '0;
        case (s_addr_i)
            REG_STATUS: begin
                s_dat_o[STAT_DONE_EN]  = done_en;
                s_dat_o[STAT_ERR_EN]   = err_en;
                s_dat_o[STAT_DONE_ISR] = done_isr;
                s_dat_o[STAT_ERR_ISR]  = err_isr;
                s_dat_o[STAT_BUSY]     = busy;
            end
            REG_SIZE:       s_dat_o[$bits(size_t)-1:0] = size_o;
            REG_START_ADDR: s_dat_o = start_addr_o;
            REG_DEST:       s_dat_o[9:0] = {class_o, dest_o};
            REG_ERRORS:     s_dat_o[1:0] = errors;
            default:        s_dat_o = '0;    // ctrl reads as zero
        endcase
    end

    // a done only ends a send that is running
    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        send_done_i |-> busy);

endmodule

// ==== logic/ni_crc32.sv ====
`timescale 1ns/10ps

module ni_crc32 (
    input  logic          clk,
    input  logic          reset,
    input  logic          clear_i,
    input  logic          enable_i,
    input  ni_pkg::word_t data_i,
    output ni_pkg::word_t crc_o
);
    import ni_pkg::*;

    word_t state;

    // bit 0 first, so the low byte goes in first
    function automatic word_t crc_word(input word_t crc_in, input word_t data);
        word_t c;
        c = crc_in;
        for (int i = 0; i < $bits(word_t); i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= '1;
        else if (clear_i)
            state <= '1;
        else if (enable_i)
            state <= crc_word(state, data_i);
    end

    assign crc_o = ~state;   // final xor

endmodule

// ==== logic/ni_pkg.sv ====
package ni_pkg;

    typedef logic [31:0] word_t;      // flit payload, register and memory data
    typedef logic [31:0] maddr_t;     // byte address on the read master
    typedef logic [7:0]  eaddr_t;     // endpoint address
    typedef logic [1:0]  pck_class_t;
    typedef logic [9:0]  size_t;      // word count of one transaction
    typedef logic [33:0] flit_t;      // {hdr, tail, payload}

    typedef enum logic [1:0] {ITEM_HDR, ITEM_BODY, ITEM_TAIL} item_kind_t;
    typedef enum logic [2:0] {DMA_IDLE, DMA_HDR, DMA_READ, DMA_PUSH, DMA_TAIL} dma_state_t;

    localparam int BUF_DEPTH  = 4;    // router input buffer slots
    localparam int REG_ADDR_W = 3;

    // flit flag positions
    localparam int FLIT_HDR_BIT  = 33;
    localparam int FLIT_TAIL_BIT = 32;

    localparam logic [REG_ADDR_W-1:0] REG_STATUS     = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_SIZE       = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_START_ADDR = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_DEST       = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL       = 3'd4;
    localparam logic [REG_ADDR_W-1:0] REG_ERRORS     = 3'd5;

    localparam int STAT_DONE_EN  = 0;
    localparam int STAT_ERR_EN   = 1;
    localparam int STAT_DONE_ISR = 2;
    localparam int STAT_ERR_ISR  = 3;
    localparam int STAT_BUSY     = 4;

    localparam int ERR_SIZE          = 0;
    localparam int ERR_ILLEGAL_START = 1;

    localparam int HDR_DEST_LSB  = 0;
    localparam int HDR_SRC_LSB   = 8;
    localparam int HDR_CLASS_LSB = 16;

    localparam word_t CRC_POLY = 32'hEDB88320;   // reflected IEEE

endpackage
